// File: src.f
source/corep_pkg.sv
source/bram_1rport_1wport.sv
source/btb_plru.sv
source/btb.sv
source/next_pc_select.sv
source/fetch_predictor.sv
verification/tb_fetch_predictor.sv

// File: verification/tb_fetch_predictor.sv
`default_nettype none

module tb_fetch_predictor import corep_pkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk = 1'b0;
    logic        rst;
    ASID_t       arch_asid;
    logic        fetch_valid;
    PC38_t       fetch_pc38;
    logic        pred_valid;
    logic        pred_taken;
    fetch_lane_t pred_lane;
    PC38_t       pred_next_pc38;
    logic        update_req;
    PC38_t       update_pc38;
    BTB_info_t   update_info;
    logic        update_hit;
    logic        update_hit_way;    // two ways by default
    logic        update_ack;

    // expected prediction driven with each fetch
    logic        exp_taken;
    fetch_lane_t exp_lane;
    PC38_t       exp_next;

    int          sets;
    int          set_bits;
    int          assoc;
    int          wait_limit;
    logic [31:0] rng_state = 32'h328ca358;

    // reference model with one record per written set, tag and lane
    int          m_set[$];
    int          m_tag[$];
    int          m_lane[$];
    BTB_info_t   m_info[$];

    fetch_predictor fetch_predictor_i (
        .CLK(clk),
        .rst(rst),
        .arch_asid(arch_asid),
        .fetch_valid(fetch_valid),
        .fetch_pc38(fetch_pc38),
        .pred_valid(pred_valid),
        .pred_taken(pred_taken),
        .pred_lane(pred_lane),
        .pred_next_pc38(pred_next_pc38),
        .update_req(update_req),
        .update_pc38(update_pc38),
        .update_info(update_info),
        .update_hit(update_hit),
        .update_hit_way(update_hit_way),
        .update_ack(update_ack)
    );

    always #2 clk = ~clk;

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        $display("[FAIL] %0d ns: %s", $time, what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------------
    // checks

    pred_taken_matches: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |-> ##2 (pred_valid && pred_taken == $past(exp_taken, 2)))
        else report_mismatch("pred_valid or pred_taken differs from the model");

    pred_target_matches: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |-> ##2 (pred_next_pc38 == $past(exp_next, 2)
            && (!pred_taken || pred_lane == $past(exp_lane, 2))))
        else report_mismatch("pred_next_pc38 or pred_lane differs from the model");

    ack_rises_with_req: assert property (@(posedge clk) disable iff (rst)
        $rose(update_ack) |-> $past(update_req))
        else report_mismatch("update_ack rose without update_req");

    ack_falls_after_req: assert property (@(posedge clk) disable iff (rst)
        update_ack && !update_req |=> !update_ack)
        else report_mismatch("update_ack stayed high after update_req dropped");

    ack_low_while_clearing: assert property (@(posedge clk) disable iff (rst)
        fetch_predictor_i.btb_i.clearing |-> !update_ack)
        else report_mismatch("update_ack high during the clearing sweep");

    // ------------------------------------------------------------------------
    // stimulus helpers and reference model

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int set_of(input PC38_t pc, input ASID_t asid);
        return int'((pc >> LOG_FETCH_LANES) & PC38_t'(sets - 1)) ^ (int'(asid) & (sets - 1));
    endfunction

    function automatic int tag_of(input PC38_t pc, input ASID_t asid);
        return int'((pc >> (LOG_FETCH_LANES + set_bits)) & PC38_t'((1 << BTB_TAG_BITS) - 1))
            ^ int'(asid);
    endfunction

    // random address whose hashed set and lane are fixed
    function automatic PC38_t pc_in_set(input int set, input int lane, input ASID_t asid);
        PC38_t pc;
        pc = PC38_t'({next_rand(), next_rand()});
        pc = pc & ~(PC38_t'(sets - 1) << LOG_FETCH_LANES) & ~PC38_t'(FETCH_LANES - 1);
        pc = pc | (PC38_t'((set ^ int'(asid)) & (sets - 1)) << LOG_FETCH_LANES);
        return pc | PC38_t'(lane);
    endfunction

    function automatic logic find_entry(input int set, input int tag, input int lane,
                                        output BTB_info_t info);
        info = '0;
        for (int i = 0; i < m_set.size(); i++) begin
            if (m_set[i] == set && m_tag[i] == tag && m_lane[i] == lane) begin
                info = m_info[i];
                return info.action != ACTION_NONE;
            end
        end
        return 1'b0;
    endfunction

    task automatic predict(input PC38_t pc, input ASID_t asid, output logic taken,
                           output fetch_lane_t lane, output PC38_t next);
        BTB_info_t info;
        taken = 1'b0;
        lane = '0;
        next = ((pc >> LOG_FETCH_LANES) + 1) << LOG_FETCH_LANES;
        for (int l = int'(pc[LOG_FETCH_LANES-1:0]); l < FETCH_LANES && !taken; l++) begin
            if (find_entry(set_of(pc, asid), tag_of(pc, asid), l, info)) begin
                if (info.action != ACTION_BRANCH || info.taken_ctr[1]) begin
                    taken = 1'b1;
                    lane = fetch_lane_t'(l);
                    next = (pc & ~PC38_t'(16'hffff)) | PC38_t'(info.target_low);
                end
            end
        end
    endtask

    task automatic issue_fetch(input PC38_t pc, input ASID_t asid);
        logic        taken;
        fetch_lane_t lane;
        PC38_t       next;
        predict(pc, asid, taken, lane, next);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_pc38 <= pc;
        arch_asid <= asid;
        exp_taken <= taken;
        exp_lane <= lane;
        exp_next <= next;
    endtask

    // four-phase update followed by a model record
    task automatic send_update(input PC38_t pc, input ASID_t asid, input BTB_info_t info,
                               input logic hit, input logic way);
        int n;
        int slot;
        @(posedge clk);
        fetch_valid <= 1'b0;
        arch_asid <= asid;
        update_pc38 <= pc;
        update_info <= info;
        update_hit <= hit;
        update_hit_way <= way;
        update_req <= 1'b1;
        n = 0;
        @(posedge clk);
        while (!update_ack && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (!update_ack) stop_run("timeout waiting for update_ack to rise");
        update_req <= 1'b0;
        n = 0;
        @(posedge clk);
        while (update_ack && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (update_ack) stop_run("timeout waiting for update_ack to fall");
        slot = -1;
        for (int i = 0; i < m_set.size(); i++) begin
            if (m_set[i] == set_of(pc, asid) && m_tag[i] == tag_of(pc, asid)
                    && m_lane[i] == int'(pc[LOG_FETCH_LANES-1:0])) begin
                slot = i;
            end
        end
        if (slot >= 0) begin
            m_info[slot] = info;
        end else begin
            m_set.push_back(set_of(pc, asid));
            m_tag.push_back(tag_of(pc, asid));
            m_lane.push_back(int'(pc[LOG_FETCH_LANES-1:0]));
            m_info.push_back(info);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        fetch_valid <= 1'b0;
        update_req <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        m_set.delete();
        m_tag.delete();
        m_lane.delete();
        m_info.delete();
    endtask

    task automatic wait_clear_done();
        int n;
        n = 0;
        @(posedge clk);
        while (fetch_predictor_i.btb_i.clearing && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (fetch_predictor_i.btb_i.clearing) stop_run("timeout waiting for the RAM clear");
    endtask

    // ------------------------------------------------------------------------
    // test sequence

    initial begin
        PC38_t pc;
        ASID_t asid;
        int    set;
        int    lane;
        rst = 1'b1;
        arch_asid = '0;
        fetch_valid = 1'b0;
        fetch_pc38 = '0;
        update_req = 1'b0;
        update_pc38 = '0;
        update_info = '0;
        update_hit = 1'b0;
        update_hit_way = 1'b0;
        exp_taken = 1'b0;
        exp_lane = '0;
        exp_next = '0;
        sets = fetch_predictor_i.BTB_SETS;
        assoc = fetch_predictor_i.BTB_ASSOC;
        set_bits = $clog2(sets);
        wait_limit = sets + 16;
        set = 0;

        apply_reset();
        wait_clear_done();

        // back to back fetches on an empty table all fall through
        repeat (24) issue_fetch(PC38_t'({next_rand(), next_rand()}), ASID_t'(next_rand()));

        // jump and call entries with start lanes on both sides and a foreign asid
        repeat (4) begin
            asid = ASID_t'(next_rand());
            lane = 1 + int'(next_rand() % 2);
            pc = pc_in_set(set, lane, asid);
            set++;
            send_update(pc, asid, '{(next_rand() % 2) ? ACTION_JUMP : ACTION_CALL, 2'b00,
                                    16'(next_rand())}, 1'b0, 1'b0);
            for (int st = 0; st < FETCH_LANES; st++) begin
                issue_fetch((pc & ~PC38_t'(FETCH_LANES - 1)) | PC38_t'(st), asid);
            end
            issue_fetch(pc, asid ^ ASID_t'(1 + next_rand() % 511));
        end

        // weak branch that is then strengthened in its own way
        // an untouched set and lane sends the first write to way 0
        asid = ASID_t'(next_rand());
        lane = int'(next_rand() % FETCH_LANES);
        pc = pc_in_set(set, lane, asid);
        set++;
        send_update(pc, asid, '{ACTION_BRANCH, 2'b01, 16'(next_rand())}, 1'b0, 1'b0);
        issue_fetch(pc & ~PC38_t'(FETCH_LANES - 1), asid);
        send_update(pc, asid, '{ACTION_BRANCH, 2'b11, 16'(next_rand())}, 1'b1, 1'b0);
        issue_fetch(pc & ~PC38_t'(FETCH_LANES - 1), asid);

        // fill every way of one set and lane with distinct tags
        asid = ASID_t'(next_rand());
        lane = int'(next_rand() % FETCH_LANES);
        pc = pc_in_set(set, lane, asid);
        set++;
        for (int k = 0; k < assoc; k++) begin
            send_update(pc + (PC38_t'(k) << (LOG_FETCH_LANES + set_bits)), asid,
                        '{ACTION_JUMP, 2'b00, 16'(next_rand())}, 1'b0, 1'b0);
        end
        for (int k = 0; k < assoc; k++) begin
            issue_fetch(pc + (PC38_t'(k) << (LOG_FETCH_LANES + set_bits)), asid);
        end

        // update raised during the clearing sweep waits for its end
        @(posedge clk);
        fetch_valid <= 1'b0;
        repeat (3) @(posedge clk);
        apply_reset();
        asid = ASID_t'(next_rand());
        pc = pc_in_set(int'(next_rand() % sets), 0, asid);
        send_update(pc, asid, '{ACTION_CALL, 2'b00, 16'(next_rand())}, 1'b0, 1'b0);
        issue_fetch(pc, asid);

        @(posedge clk);
        fetch_valid <= 1'b0;
        repeat (4) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/fetch_predictor.sv
`default_nettype none

module fetch_predictor import corep_pkg::*; #(
    parameter int BTB_SETS  = 64,
    parameter int BTB_ASSOC = 2
) (
    input  logic                          CLK,
    input  logic                          rst,

    input  ASID_t                         arch_asid,

    // fetch request
    input  logic                          fetch_valid,
    input  PC38_t                         fetch_pc38,

    // prediction, one cycle after the lookup response
    output logic                          pred_valid,
    output logic                          pred_taken,
    output fetch_lane_t                   pred_lane,
    output PC38_t                         pred_next_pc38,

    // branch resolution updates, four-phase req/ack
    input  logic                          update_req,
    input  PC38_t                         update_pc38,
    input  BTB_info_t                     update_info,
    input  logic                          update_hit,
    input  logic [$clog2(BTB_ASSOC)-1:0]  update_hit_way,
    output logic                          update_ack
);

    // ------------------------------------------------------------------------
    // btb to next pc select

    logic                         resp_valid;
    PC38_t                        resp_pc38;
    logic [FETCH_LANES-1:0]       hit_by_lane;
    BTB_info_t [FETCH_LANES-1:0]  info_by_lane;

    btb #(
        .BTB_SETS(BTB_SETS),
        .BTB_ASSOC(BTB_ASSOC)
    ) btb_i (
        .CLK(CLK),
        .rst(rst),
        .arch_asid(arch_asid),
        .read_req_valid(fetch_valid),
        .read_req_pc38(fetch_pc38),
        .update_req(update_req),
        .update_pc38(update_pc38),
        .update_info(update_info),
        .update_hit(update_hit),
        .update_hit_way(update_hit_way),
        .update_ack(update_ack),
        .resp_valid(resp_valid),
        .resp_pc38(resp_pc38),
        .hit_by_lane(hit_by_lane),
        .info_by_lane(info_by_lane)
    );

    next_pc_select next_pc_select_i (
        .CLK(CLK),
        .rst(rst),
        .resp_valid(resp_valid),
        .resp_pc38(resp_pc38),
        .hit_by_lane(hit_by_lane),
        .info_by_lane(info_by_lane),
        .pred_valid(pred_valid),
        .pred_taken(pred_taken),
        .pred_lane(pred_lane),
        .pred_next_pc38(pred_next_pc38)
    );

endmodule

`default_nettype wire

// File: source/next_pc_select.sv
`default_nettype none

module next_pc_select import corep_pkg::*; (
    input  logic                         CLK,
    input  logic                         rst,

    // lookup response from the btb
    input  logic                         resp_valid,
    input  PC38_t                        resp_pc38,
    input  logic [FETCH_LANES-1:0]       hit_by_lane,
    input  BTB_info_t [FETCH_LANES-1:0]  info_by_lane,

    // registered prediction
    output logic                         pred_valid,
    output logic                         pred_taken,
    output fetch_lane_t                  pred_lane,
    output PC38_t                        pred_next_pc38
);

    fetch_lane_t             start_lane;
    logic [FETCH_LANES-1:0]  lane_mask;
    logic [FETCH_LANES-1:0]  taken_by_lane;
    logic [FETCH_LANES-1:0]  cand;
    logic                    sel_any;
    fetch_lane_t             sel_lane;
    PC38_t                   next_pc38;

    assign start_lane = resp_pc38[LOG_FETCH_LANES-1:0];

    // lanes at or after the start lane
    assign lane_mask = ~((FETCH_LANES'(1) << start_lane) - FETCH_LANES'(1));

    always_comb begin
        for (int lane = 0; lane < FETCH_LANES; lane++) begin
            case (info_by_lane[lane].action)
                ACTION_JUMP,
                ACTION_CALL:   taken_by_lane[lane] = hit_by_lane[lane];
                ACTION_BRANCH: taken_by_lane[lane] = hit_by_lane[lane]
                                                     && info_by_lane[lane].taken_ctr[1];
                default:       taken_by_lane[lane] = 1'b0;
            endcase
        end
    end

    assign cand = taken_by_lane & lane_mask;

    // first candidate from the low end
    always_comb begin
        sel_any = 1'b0;
        sel_lane = fetch_lane_t'(FETCH_LANES - 1);
        for (int lane = FETCH_LANES - 1; lane >= 0; lane--) begin
            if (cand[lane]) begin
                sel_any = 1'b1;
                sel_lane = fetch_lane_t'(lane);
            end
        end
    end

    // taken: splice target low bits, else start of the next block
    assign next_pc38 = sel_any
        ? {resp_pc38[37:16], info_by_lane[sel_lane].target_low}
        : {resp_pc38[37:LOG_FETCH_LANES] + 1'b1, {LOG_FETCH_LANES{1'b0}}};

    always_ff @(posedge CLK) begin
        if (rst) begin
            pred_valid <= 1'b0;
            pred_taken <= 1'b0;
        end else begin
            pred_valid <= resp_valid;
            pred_taken <= resp_valid && sel_any;
        end
    end

    always_ff @(posedge CLK) begin
        pred_lane <= sel_lane;
        pred_next_pc38 <= next_pc38;
    end

    taken_is_valid: assert property (@(posedge CLK) disable iff (rst)
        pred_taken |-> pred_valid && $past(resp_valid));

endmodule

`default_nettype wire

// File: source/btb.sv
`default_nettype none

module btb import corep_pkg::*; #(
    parameter int BTB_SETS  = 64,
    parameter int BTB_ASSOC = 2
) (
    input  logic                                CLK,
    input  logic                                rst,

    input  ASID_t                               arch_asid,

    // lookup request
    input  logic                                read_req_valid,
    input  PC38_t                               read_req_pc38,

    // update handshake
    input  logic                                update_req,
    input  PC38_t                               update_pc38,
    input  BTB_info_t                           update_info,
    input  logic                                update_hit,
    input  logic [$clog2(BTB_ASSOC)-1:0]        update_hit_way,
    output logic                                update_ack,

    // lookup response, one cycle after the request
    output logic                                resp_valid,
    output PC38_t                               resp_pc38,
    output logic [FETCH_LANES-1:0]              hit_by_lane,
    output BTB_info_t [FETCH_LANES-1:0]         info_by_lane
);

    localparam int LOG_SETS = $clog2(BTB_SETS);
    localparam int WAY_BITS = $clog2(BTB_ASSOC);

    // ------------------------------------------------------------------------
    // decode: index and tag hashing

    function automatic logic [LOG_SETS-1:0] index_hash(input PC38_t pc, input ASID_t asid);
        index_hash = pc[LOG_FETCH_LANES +: LOG_SETS] ^ LOG_SETS'(asid);
    endfunction

    function automatic logic [BTB_TAG_BITS-1:0] tag_hash(input PC38_t pc, input ASID_t asid);
        tag_hash = pc[LOG_FETCH_LANES+LOG_SETS +: BTB_TAG_BITS] ^ BTB_TAG_BITS'(asid);
    endfunction

    BTB_entry_t [FETCH_LANES-1:0][BTB_ASSOC-1:0]                      rd_set;
    BTB_entry_t [FETCH_LANES-1:0][BTB_ASSOC-1:0]                      wr_set;
    logic [FETCH_LANES-1:0][BTB_ASSOC-1:0][BTB_ENTRY_BYTES-1:0]       wr_byten;
    logic [LOG_SETS-1:0]                                              wr_index;
    logic [FETCH_LANES*BTB_ASSOC-1:0]                                 way_sel;

    ASID_t                                  resp_asid;
    logic                                   resp_blank;
    logic [BTB_TAG_BITS-1:0]                resp_tag;
    logic [FETCH_LANES-1:0][WAY_BITS-1:0]   hit_way_by_lane;

    logic                   clearing;
    logic [LOG_SETS-1:0]    clear_idx;

    logic                   write_fire;
    fetch_lane_t            upd_lane;
    logic [WAY_BITS-1:0]    victim_way;
    logic [WAY_BITS-1:0]    write_way;
    BTB_entry_t             upd_entry;

    logic                   look_touch;
    fetch_lane_t            look_lane;
    logic                   touch_valid;
    logic [LOG_SETS-1:0]    touch_index;
    fetch_lane_t            touch_lane;
    logic [WAY_BITS-1:0]    touch_way;

    // ------------------------------------------------------------------------
    // execute: lookup against the ram

    always_ff @(posedge CLK) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_blank <= 1'b1;
        end else begin
            resp_valid <= read_req_valid;
            resp_blank <= clearing;
        end
    end

    always_ff @(posedge CLK) begin
        resp_pc38 <= read_req_pc38;
        resp_asid <= arch_asid;
    end

    assign resp_tag = tag_hash(resp_pc38, resp_asid);

    // lowest hitting way wins
    always_comb begin
        for (int lane = 0; lane < FETCH_LANES; lane++) begin
            hit_by_lane[lane] = 1'b0;
            hit_way_by_lane[lane] = '0;
            info_by_lane[lane] = rd_set[lane][0].info;
            for (int way = BTB_ASSOC - 1; way >= 0; way--) begin
                if (rd_set[lane][way].info.action != ACTION_NONE
                        && rd_set[lane][way].tag == resp_tag && !resp_blank) begin
                    hit_by_lane[lane] = 1'b1;
                    hit_way_by_lane[lane] = WAY_BITS'(way);
                    info_by_lane[lane] = rd_set[lane][way].info;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // update handshake and reset clearing sweep

    always_ff @(posedge CLK) begin
        if (rst) begin
            clearing <= 1'b1;
            clear_idx <= '0;
        end else if (clearing) begin
            clear_idx <= clear_idx + 1'b1;
            if (clear_idx == LOG_SETS'(BTB_SETS - 1)) begin
                clearing <= 1'b0;
            end
        end
    end

    assign write_fire = update_req && !update_ack && !clearing;

    always_ff @(posedge CLK) begin
        if (rst) begin
            update_ack <= 1'b0;
        end else if (write_fire) begin
            update_ack <= 1'b1;
        end else if (!update_req) begin
            update_ack <= 1'b0;
        end
    end

    assign upd_lane  = update_pc38[LOG_FETCH_LANES-1:0];
    assign write_way = update_hit ? update_hit_way : victim_way;

    always_comb begin
        upd_entry.pad  = '0;
        upd_entry.info = update_info;
        upd_entry.tag  = tag_hash(update_pc38, arch_asid);
    end

    // replicate the entry, enable bytes of one lane and way only
    always_comb begin
        wr_set = '0;
        wr_byten = '0;
        wr_index = index_hash(update_pc38, arch_asid);
        if (clearing) begin
            wr_byten = '1;
            wr_index = clear_idx;
        end else begin
            for (int lane = 0; lane < FETCH_LANES; lane++) begin
                for (int way = 0; way < BTB_ASSOC; way++) begin
                    wr_set[lane][way] = upd_entry;
                end
            end
            if (write_fire) begin
                wr_byten[upd_lane][write_way] = '1;
            end
        end
    end

    // plru touch, a write beats a lookup hit
    always_comb begin
        look_touch = 1'b0;
        look_lane = '0;
        for (int lane = FETCH_LANES - 1; lane >= 0; lane--) begin
            if (hit_by_lane[lane] && lane >= int'(resp_pc38[LOG_FETCH_LANES-1:0])) begin
                look_touch = 1'b1;
                look_lane = fetch_lane_t'(lane);
            end
        end
        touch_valid = write_fire || (resp_valid && look_touch);
        touch_index = write_fire ? wr_index : index_hash(resp_pc38, resp_asid);
        touch_lane  = write_fire ? upd_lane : look_lane;
        touch_way   = write_fire ? write_way : hit_way_by_lane[look_lane];
    end

    bram_1rport_1wport #(
        .INNER_WIDTH($bits(rd_set)),
        .OUTER_WIDTH(BTB_SETS)
    ) bram_i (
        .CLK(CLK),
        .rst(rst),
        .ren(read_req_valid),
        .rindex(index_hash(read_req_pc38, arch_asid)),
        .rdata(rd_set),
        .wen_byte(wr_byten),
        .windex(wr_index),
        .wdata(wr_set)
    );

    btb_plru #(
        .BTB_SETS(BTB_SETS),
        .BTB_ASSOC(BTB_ASSOC)
    ) plru_i (
        .CLK(CLK),
        .rst(rst),
        .touch_valid(touch_valid),
        .touch_index(touch_index),
        .touch_lane(touch_lane),
        .touch_way(touch_way),
        .victim_index(index_hash(update_pc38, arch_asid)),
        .victim_lane(upd_lane),
        .victim_way(victim_way)
    );

    always_comb begin
        for (int lane = 0; lane < FETCH_LANES; lane++) begin
            for (int way = 0; way < BTB_ASSOC; way++) begin
                way_sel[lane*BTB_ASSOC + way] = |wr_byten[lane][way];
            end
        end
    end

    ack_needs_req: assert property (@(posedge CLK) disable iff (rst)
        $rose(update_ack) |-> $past(update_req) && !$past(clearing));

    one_way_written: assert property (@(posedge CLK) disable iff (rst)
        !clearing |-> $onehot0(way_sel));

endmodule

`default_nettype wire

// File: source/btb_plru.sv
`default_nettype none

module btb_plru import corep_pkg::*; #(
    parameter int BTB_SETS  = 64,
    parameter int BTB_ASSOC = 2
) (
    input  logic                          CLK,
    input  logic                          rst,

    // tree points away from a touched way
    input  logic                          touch_valid,
    input  logic [$clog2(BTB_SETS)-1:0]   touch_index,
    input  fetch_lane_t                   touch_lane,
    input  logic [$clog2(BTB_ASSOC)-1:0]  touch_way,

    // victim lookup
    input  logic [$clog2(BTB_SETS)-1:0]   victim_index,
    input  fetch_lane_t                   victim_lane,
    output logic [$clog2(BTB_ASSOC)-1:0]  victim_way
);

    localparam int WAY_BITS  = $clog2(BTB_ASSOC);
    localparam int TREE_BITS = BTB_ASSOC - 1;

    // heap order with children 2n+1 and 2n+2 below node n
    logic [TREE_BITS-1:0] plru_state [BTB_SETS*FETCH_LANES];

    logic [TREE_BITS-1:0] victim_tree;

    function automatic logic [TREE_BITS-1:0] tree_touch(
        input logic [TREE_BITS-1:0] tree,
        input logic [WAY_BITS-1:0]  way
    );
        int   node;
        logic dir;
        tree_touch = tree;
        node = 0;
        for (int lvl = WAY_BITS - 1; lvl >= 0; lvl--) begin
            dir = way[lvl];
            tree_touch[node] = ~dir;
            node = 2 * node + 1 + int'(dir);
        end
    endfunction

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < BTB_SETS * FETCH_LANES; i++) begin
                plru_state[i] <= '0;
            end
        end else if (touch_valid) begin
            plru_state[{touch_index, touch_lane}] <=
                tree_touch(plru_state[{touch_index, touch_lane}], touch_way);
        end
    end

    // follow the tree bits down to a leaf
    always_comb begin
        int node;
        victim_tree = plru_state[{victim_index, victim_lane}];
        node = 0;
        victim_way = '0;
        for (int lvl = WAY_BITS - 1; lvl >= 0; lvl--) begin
            victim_way[lvl] = victim_tree[node];
            node = 2 * node + 1 + int'(victim_tree[node]);
        end
    end

    touch_in_range: assert property (@(posedge CLK) disable iff (rst)
        touch_valid |-> !$isunknown({touch_index, touch_lane, touch_way}));

endmodule

`default_nettype wire

// File: source/bram_1rport_1wport.sv
`default_nettype none

module bram_1rport_1wport #(
    parameter int INNER_WIDTH = 32,
    parameter int OUTER_WIDTH = 64
) (
    input  logic                            CLK,
    input  logic                            rst,

    // read port, data one cycle after ren
    input  logic                            ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0]  rindex,
    output logic [INNER_WIDTH-1:0]          rdata,

    // write port, one enable per byte
    input  logic [INNER_WIDTH/8-1:0]        wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0]  windex,
    input  logic [INNER_WIDTH-1:0]          wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // per byte write
    always_ff @(posedge CLK) begin
        for (int b = 0; b < INNER_WIDTH / 8; b++) begin
            if (wen_byte[b]) begin
                mem[windex][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // registered read, old data wins on a same index write
    always_ff @(posedge CLK) begin
        if (rst) begin
            rdata <= '0;
        end else if (ren) begin
            rdata <= mem[rindex];
        end
    end

endmodule

`default_nettype wire

// File: source/corep_pkg.sv
`default_nettype none

package corep_pkg;

    // ------------------------------------------------------------------------
    // fetch block geometry

    localparam int FETCH_LANES = 4;
    localparam int LOG_FETCH_LANES = $clog2(FETCH_LANES);

    // fetch address in instruction units, low bits are the lane
    typedef logic [37:0] PC38_t;

    typedef logic [LOG_FETCH_LANES-1:0] fetch_lane_t;

    // address space identifier
    typedef logic [8:0] ASID_t;

    // ------------------------------------------------------------------------
    // btb entry encoding

    typedef enum logic [1:0] {
        ACTION_NONE   = 2'd0,
        ACTION_BRANCH = 2'd1,
        ACTION_JUMP   = 2'd2,
        ACTION_CALL   = 2'd3
    } action_t;

    // prediction info, target replaces the low 16 bits of the fetch address
    typedef struct packed {
        action_t     action;
        logic [1:0]  taken_ctr;
        logic [15:0] target_low;
    } BTB_info_t;

    localparam int BTB_TAG_BITS = 9;

    // pad so one way is a whole number of bytes
    localparam int BTB_ENTRY_RAW_BITS = $bits(BTB_info_t) + BTB_TAG_BITS;
    localparam int BTB_ENTRY_PAD_BITS = (8 - (BTB_ENTRY_RAW_BITS % 8)) % 8;

    typedef struct packed {
        logic [BTB_ENTRY_PAD_BITS-1:0] pad;
        BTB_info_t                     info;
        logic [BTB_TAG_BITS-1:0]       tag;
    } BTB_entry_t;

    localparam int BTB_ENTRY_BYTES = $bits(BTB_entry_t) / 8;

endpackage

`default_nettype wire
